// ==== axi_sram.sv ====
// 64-bit word memory model
// read channel with held data beat, single-beat write channel
// with strobes and an error response outside the mapped range

`timescale 1ns/1ps

module axi_sram (
    input  logic        clk,
    input  logic        rst,
    // read channel
    input  logic [31:0] araddr,
    input  logic [2:0]  arsize,
    input  logic        arvalid,
    output logic        arready,
    output logic [63:0] rdata,
    output logic        rvalid,
    input  logic        rready,
    // write channel
    input  logic [31:0] awaddr,
    input  logic [2:0]  awsize,
    input  logic        awvalid,
    output logic        awready,
    input  logic [63:0] wdata,
    input  logic [7:0]  wstrb,
    input  logic        wlast,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready
);

    logic [63:0]                    mem [lsu_pkg::SRAM_WORDS];
    logic [lsu_pkg::SRAM_IDX_W-1:0] rd_idx;
    logic [lsu_pkg::SRAM_IDX_W-1:0] wr_idx;
    logic [31:0]                    rd_off;
    logic [31:0]                    wr_off;
    logic                           rd_ok;
    logic                           wr_ok;
    logic                           wr_hs;

    // first and last byte of the access both inside the map
    function automatic logic in_range(input logic [31:0] addr, input logic [2:0] size);
        logic [31:0] last;
        last = addr + ((32'd1 << size) - 32'd1);
        return (addr >= lsu_pkg::SRAM_BASE) && (last < lsu_pkg::SRAM_LIMIT);
    endfunction

    assign rd_off = araddr - lsu_pkg::SRAM_BASE;
    assign wr_off = awaddr - lsu_pkg::SRAM_BASE;
    assign rd_idx = rd_off[3 +: lsu_pkg::SRAM_IDX_W];
    assign wr_idx = wr_off[3 +: lsu_pkg::SRAM_IDX_W];
    assign rd_ok  = in_range(araddr, arsize);
    assign wr_ok  = in_range(awaddr, awsize) & wlast;

    // ==============================
    // read channel
    // ==============================

    // one beat in flight at a time
    assign arready = ~rvalid;

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (arvalid & arready) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid & arready) begin
            rdata <= rd_ok ? mem[rd_idx] : 64'b0;
        end
    end

    // ==============================
    // write channel
    // ==============================

    // address and data accepted only together
    assign awready = ~bvalid & wvalid;
    assign wready  = ~bvalid & awvalid;
    assign wr_hs   = awvalid & awready & wvalid & wready;

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
            bresp  <= lsu_pkg::RESP_OKAY;
        end else if (wr_hs) begin
            bvalid <= 1'b1;
            bresp  <= wr_ok ? lsu_pkg::RESP_OKAY : lsu_pkg::RESP_SLVERR;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    // strobed byte update
    always_ff @(posedge clk) begin
        if (wr_hs && wr_ok) begin
            for (int b = 0; b < 8; b++) begin
                if (wstrb[b]) begin
                    mem[wr_idx][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

// ==== lsu_data_mem.sv ====
// load/store unit of the memory stage
// read and write channel FSMs, byte lane alignment,
// write strobes and load sign/zero extension

`timescale 1ns/1ps

module lsu_data_mem (
    input  logic                clk,
    input  logic                rst,
    // pipeline side
    input  logic                raddr_change,
    input  logic                waddr_change,
    input  logic [31:0]         raddr,
    input  logic [31:0]         waddr,
    input  logic [31:0]         wdata,
    input  lsu_pkg::mem_width_e width,
    output logic [31:0]         rdata,
    output logic                rvalid,
    output logic                wready,
    output logic                error,
    // read client towards the arbiter
    output logic [31:0]         d_araddr,
    output logic [2:0]          d_arsize,
    output logic                d_arvalid,
    input  logic                d_arready,
    input  logic [63:0]         d_rdata,
    input  logic                d_rvalid,
    output logic                d_rready,
    // write channel
    output logic [31:0]         awaddr,
    output logic [2:0]          awsize,
    output logic                awvalid,
    input  logic                awready,
    output logic [63:0]         wdata_bus,
    output logic [7:0]          wstrb,
    output logic                wlast,
    output logic                wvalid,
    input  logic                wready_bus,
    input  logic [1:0]          bresp,
    input  logic                bvalid,
    output logic                bready
);

    lsu_pkg::chan_state_e r_state;
    lsu_pkg::chan_state_e w_state;
    logic                 r_pending;
    logic                 w_pending;
    logic                 ar_hs;
    logic                 r_hs;
    logic                 aw_w_hs;
    logic                 b_hs;
    logic [2:0]           access_size;
    logic [7:0]           base_strb;
    logic [63:0]          load_beat;
    logic [31:0]          load_ext;

    // ==============================
    // size and lane helpers
    // ==============================

    always_comb begin
        case (width)
            lsu_pkg::MEM_BYTE, lsu_pkg::MEM_BYTE_U: access_size = lsu_pkg::SIZE_BYTE;
            lsu_pkg::MEM_HALF, lsu_pkg::MEM_HALF_U: access_size = lsu_pkg::SIZE_HALF;
            default:                                access_size = lsu_pkg::SIZE_WORD;
        endcase
    end

    // strobe before lane shift
    always_comb begin
        case (access_size)
            lsu_pkg::SIZE_BYTE: base_strb = 8'b0000_0001;
            lsu_pkg::SIZE_HALF: base_strb = 8'b0000_0011;
            default:            base_strb = 8'b0000_1111;
        endcase
    end

    // load lane moved down to bit 0
    assign load_beat = d_rdata >> {raddr[2:0], 3'b000};

    always_comb begin
        case (width)
            lsu_pkg::MEM_BYTE:   load_ext = {{24{load_beat[7]}}, load_beat[7:0]};
            lsu_pkg::MEM_BYTE_U: load_ext = {24'b0, load_beat[7:0]};
            lsu_pkg::MEM_HALF:   load_ext = {{16{load_beat[15]}}, load_beat[15:0]};
            lsu_pkg::MEM_HALF_U: load_ext = {16'b0, load_beat[15:0]};
            default:             load_ext = load_beat[31:0];
        endcase
    end

    // ==============================
    // read channel
    // ==============================

    assign d_araddr  = raddr;
    assign d_arsize  = access_size;
    assign d_arvalid = (r_state == lsu_pkg::CH_IDLE) & r_pending;
    assign d_rready  = (r_state == lsu_pkg::CH_BUSY);
    assign ar_hs     = d_arvalid & d_arready;
    assign r_hs      = d_rvalid & d_rready;

    // low from the change pulse until the data beat is taken
    assign rvalid = (r_state == lsu_pkg::CH_IDLE) & ~raddr_change & ~r_pending;

    always_ff @(posedge clk) begin
        if (rst) begin
            r_state   <= lsu_pkg::CH_IDLE;
            r_pending <= 1'b0;
        end else begin
            case (r_state)
                lsu_pkg::CH_IDLE: begin
                    if (ar_hs) begin
                        r_state   <= lsu_pkg::CH_BUSY;
                        r_pending <= 1'b0;
                    end else if (raddr_change) begin
                        r_pending <= 1'b1;
                    end
                end
                lsu_pkg::CH_BUSY: begin
                    if (r_hs) begin
                        r_state <= lsu_pkg::CH_IDLE;
                    end
                end
            endcase
        end
    end

    // held load result, the bus beat is gone after the handshake
    always_ff @(posedge clk) begin
        if (r_hs) begin
            rdata <= load_ext;
        end
    end

    // ==============================
    // write channel
    // ==============================

    assign awaddr    = waddr;
    assign awsize    = access_size;
    assign awvalid   = (w_state == lsu_pkg::CH_IDLE) & w_pending;
    assign wvalid    = awvalid;
    assign wlast     = wvalid;
    assign wdata_bus = {32'b0, wdata} << {waddr[2:0], 3'b000};
    assign wstrb     = base_strb << waddr[2:0];
    assign bready    = (w_state == lsu_pkg::CH_BUSY);

    // address and data must go in the same cycle
    assign aw_w_hs = awvalid & awready & wvalid & wready_bus;
    assign b_hs    = bvalid & bready;

    assign wready = (w_state == lsu_pkg::CH_IDLE) & ~waddr_change & ~w_pending;

    always_ff @(posedge clk) begin
        if (rst) begin
            w_state   <= lsu_pkg::CH_IDLE;
            w_pending <= 1'b0;
        end else begin
            case (w_state)
                lsu_pkg::CH_IDLE: begin
                    if (aw_w_hs) begin
                        w_state   <= lsu_pkg::CH_BUSY;
                        w_pending <= 1'b0;
                    end else if (waddr_change) begin
                        w_pending <= 1'b1;
                    end
                end
                lsu_pkg::CH_BUSY: begin
                    if (b_hs) begin
                        w_state <= lsu_pkg::CH_IDLE;
                    end
                end
            endcase
        end
    end

    // sticky until the next write response
    always_ff @(posedge clk) begin
        if (rst) begin
            error <= 1'b0;
        end else if (b_hs) begin
            error <= (bresp != lsu_pkg::RESP_OKAY);
        end
    end

endmodule

// ==== lsu_pkg.sv ====
// shared definitions for the memory stage
// access widths, channel states, bus size and response codes,
// and the SRAM memory map

package lsu_pkg;

    // access width and signedness of a load or store
    typedef enum logic [2:0] {
        MEM_BYTE   = 3'd0,
        MEM_HALF   = 3'd1,
        MEM_WORD   = 3'd2,
        MEM_BYTE_U = 3'd3,
        MEM_HALF_U = 3'd4
    } mem_width_e;

    // two-state channel FSM, also used for the arbiter lock
    typedef enum logic {
        CH_IDLE = 1'b0,
        CH_BUSY = 1'b1
    } chan_state_e;

    // bus size codes
    localparam logic [2:0] SIZE_BYTE = 3'd0;
    localparam logic [2:0] SIZE_HALF = 3'd1;
    localparam logic [2:0] SIZE_WORD = 3'd2;

    // write response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // memory map, 64-bit words
    localparam logic [31:0] SRAM_BASE  = 32'h8000_0000;
    localparam int          SRAM_WORDS = 512;
    localparam int          SRAM_IDX_W = $clog2(SRAM_WORDS);
    localparam logic [31:0] SRAM_LIMIT = SRAM_BASE + 32'(SRAM_WORDS * 8);

endpackage

// ==== mem_stage_top.f ====
lsu_pkg.sv
lsu_data_mem.sv
read_arbiter.sv
axi_sram.sv
mem_stage_top.sv
tb_mem_stage_assertions.sv
tb_mem_stage.sv

// ==== mem_stage_top.sv ====
// memory stage top level
// LSU, read arbiter and SRAM model wired together

`timescale 1ns/1ps

module mem_stage_top (
    input  logic                clk,
    input  logic                rst,
    // pipeline side
    input  logic                raddr_change,
    input  logic                waddr_change,
    input  logic [31:0]         raddr,
    input  logic [31:0]         waddr,
    input  logic [31:0]         wdata,
    input  lsu_pkg::mem_width_e width,
    output logic [31:0]         rdata,
    output logic                rvalid,
    output logic                wready,
    output logic                error,
    // fetch client
    input  logic [31:0]         f_araddr,
    input  logic                f_arvalid,
    output logic                f_arready,
    output logic [63:0]         f_rdata,
    output logic                f_rvalid,
    input  logic                f_rready
);

    // LSU data client to arbiter
    logic [31:0] d_araddr;
    logic [2:0]  d_arsize;
    logic        d_arvalid;
    logic        d_arready;
    logic [63:0] d_rdata;
    logic        d_rvalid;
    logic        d_rready;

    // arbiter to SRAM
    logic [31:0] araddr;
    logic [2:0]  arsize;
    logic        arvalid;
    logic        arready;
    logic [63:0] mem_rdata;
    logic        mem_rvalid;
    logic        mem_rready;

    // LSU write channel to SRAM
    logic [31:0] awaddr;
    logic [2:0]  awsize;
    logic        awvalid;
    logic        awready;
    logic [63:0] bus_wdata;
    logic [7:0]  wstrb;
    logic        wlast;
    logic        wvalid;
    logic        bus_wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;

    lsu_data_mem u_lsu (
        .clk          (clk),
        .rst          (rst),
        .raddr_change (raddr_change),
        .waddr_change (waddr_change),
        .raddr        (raddr),
        .waddr        (waddr),
        .wdata        (wdata),
        .width        (width),
        .rdata        (rdata),
        .rvalid       (rvalid),
        .wready       (wready),
        .error        (error),
        .d_araddr     (d_araddr),
        .d_arsize     (d_arsize),
        .d_arvalid    (d_arvalid),
        .d_arready    (d_arready),
        .d_rdata      (d_rdata),
        .d_rvalid     (d_rvalid),
        .d_rready     (d_rready),
        .awaddr       (awaddr),
        .awsize       (awsize),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata_bus    (bus_wdata),
        .wstrb        (wstrb),
        .wlast        (wlast),
        .wvalid       (wvalid),
        .wready_bus   (bus_wready),
        .bresp        (bresp),
        .bvalid       (bvalid),
        .bready       (bready)
    );

    read_arbiter u_arbiter (
        .clk       (clk),
        .rst       (rst),
        .d_araddr  (d_araddr),
        .d_arsize  (d_arsize),
        .d_arvalid (d_arvalid),
        .d_arready (d_arready),
        .d_rdata   (d_rdata),
        .d_rvalid  (d_rvalid),
        .d_rready  (d_rready),
        .f_araddr  (f_araddr),
        .f_arvalid (f_arvalid),
        .f_arready (f_arready),
        .f_rdata   (f_rdata),
        .f_rvalid  (f_rvalid),
        .f_rready  (f_rready),
        .araddr    (araddr),
        .arsize    (arsize),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (mem_rdata),
        .rvalid    (mem_rvalid),
        .rready    (mem_rready)
    );

    axi_sram u_sram (
        .clk     (clk),
        .rst     (rst),
        .araddr  (araddr),
        .arsize  (arsize),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (mem_rdata),
        .rvalid  (mem_rvalid),
        .rready  (mem_rready),
        .awaddr  (awaddr),
        .awsize  (awsize),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (bus_wdata),
        .wstrb   (wstrb),
        .wlast   (wlast),
        .wvalid  (wvalid),
        .wready  (bus_wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready)
    );

endmodule

// ==== read_arbiter.sv ====
// two-client read arbiter for the shared memory read port
// data client wins ties, grant locked until its data beat is taken

`timescale 1ns/1ps

module read_arbiter (
    input  logic        clk,
    input  logic        rst,
    // data client
    input  logic [31:0] d_araddr,
    input  logic [2:0]  d_arsize,
    input  logic        d_arvalid,
    output logic        d_arready,
    output logic [63:0] d_rdata,
    output logic        d_rvalid,
    input  logic        d_rready,
    // fetch client
    input  logic [31:0] f_araddr,
    input  logic        f_arvalid,
    output logic        f_arready,
    output logic [63:0] f_rdata,
    output logic        f_rvalid,
    input  logic        f_rready,
    // memory read port
    output logic [31:0] araddr,
    output logic [2:0]  arsize,
    output logic        arvalid,
    input  logic        arready,
    input  logic [63:0] rdata,
    input  logic        rvalid,
    output logic        rready
);

    lsu_pkg::chan_state_e lock;
    logic                 grant_data;
    logic                 sel_data;
    logic                 idle;

    assign idle = (lock == lsu_pkg::CH_IDLE);

    // combinational pick while idle, so no cycle is added
    assign sel_data = idle ? d_arvalid : grant_data;

    // ==============================
    // request path
    // ==============================

    assign araddr    = sel_data ? d_araddr : f_araddr;
    assign arsize    = sel_data ? d_arsize : lsu_pkg::SIZE_WORD;
    assign arvalid   = idle & (d_arvalid | f_arvalid);
    assign d_arready = idle & sel_data & arready;
    assign f_arready = idle & ~sel_data & arready;

    // ==============================
    // response path
    // ==============================

    assign d_rdata  = rdata;
    assign f_rdata  = rdata;
    assign d_rvalid = ~idle & grant_data & rvalid;
    assign f_rvalid = ~idle & ~grant_data & rvalid;
    assign rready   = ~idle & (grant_data ? d_rready : f_rready);

    always_ff @(posedge clk) begin
        if (rst) begin
            lock       <= lsu_pkg::CH_IDLE;
            grant_data <= 1'b0;
        end else begin
            case (lock)
                lsu_pkg::CH_IDLE: begin
                    if (arvalid & arready) begin
                        lock       <= lsu_pkg::CH_BUSY;
                        grant_data <= sel_data;
                    end
                end
                lsu_pkg::CH_BUSY: begin
                    // release once the granted client takes its beat
                    if (rvalid & rready) begin
                        lock <= lsu_pkg::CH_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// ==== tb_mem_stage.sv ====
// testbench for the memory stage
// LFSR driven stores, loads and fetch reads with timeouts,
// checking done by the bound assertion module

`timescale 1ns/1ps

module tb_mem_stage;

    localparam int TIMEOUT_CYCLES = 64;

    logic                clk;
    logic                rst;
    logic                raddr_change;
    logic                waddr_change;
    logic [31:0]         raddr;
    logic [31:0]         waddr;
    logic [31:0]         wdata;
    lsu_pkg::mem_width_e width;
    logic [31:0]         rdata;
    logic                rvalid;
    logic                wready;
    logic                error;
    logic [31:0]         f_araddr;
    logic                f_arvalid;
    logic                f_arready;
    logic [63:0]         f_rdata;
    logic                f_rvalid;
    logic                f_rready;
    logic                fetch_ar_hs;
    logic                fetch_r_hs;
    logic [31:0]         lfsr_state = 32'hc30b_bb83;

    mem_stage_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // fetch handshakes seen at the clock edge
    always @(posedge clk) begin
        fetch_ar_hs <= f_arvalid & f_arready;
        fetch_r_hs  <= f_rvalid & f_rready;
    end

    always @(negedge clk) begin
        if (u_dut.u_checks.fails != 0) begin
            $display("TEST FAILED");
            $fatal(1, "an assertion in the memory stage failed");
        end
    end

    // ==============================
    // helpers
    // ==============================

    // fibonacci LFSR x^32+x^22+x^2+x+1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val        = {val[30:0], fb};
        end
        return val;
    endfunction

    // random size-aligned address in the first 64 lines
    function automatic logic [31:0] pick_addr(input lsu_pkg::mem_width_e w);
        logic [31:0] line;
        logic [31:0] off;
        line = take_bits(6);
        case (w)
            lsu_pkg::MEM_BYTE, lsu_pkg::MEM_BYTE_U: off = take_bits(3);
            lsu_pkg::MEM_HALF, lsu_pkg::MEM_HALF_U: off = take_bits(2) << 1;
            default:                                off = take_bits(1) << 2;
        endcase
        return lsu_pkg::SRAM_BASE + (line << 3) + off;
    endfunction

    task automatic report_timeout(input string what);
        $display("timed out waiting for %s", what);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on a timeout");
    endtask

    task automatic store(input logic [31:0] addr, input logic [31:0] data,
                         input lsu_pkg::mem_width_e w);
        int t = 0;
        @(negedge clk);
        waddr        = addr;
        wdata        = data;
        width        = w;
        waddr_change = 1'b1;
        @(negedge clk);
        waddr_change = 1'b0;
        do begin
            @(negedge clk);
            t++;
        end while (!wready && t < TIMEOUT_CYCLES);
        if (!wready) report_timeout("wready after a store");
    endtask

    task automatic load(input logic [31:0] addr, input lsu_pkg::mem_width_e w);
        int t = 0;
        @(negedge clk);
        raddr        = addr;
        width        = w;
        raddr_change = 1'b1;
        @(negedge clk);
        raddr_change = 0;
        do begin
            @(negedge clk);
            t++;
        end while (!rvalid && t < TIMEOUT_CYCLES);
        if (!rvalid) report_timeout("rvalid after a load");
    endtask

    // fetch read, optionally holding f_rready low for a while
    task automatic fetch(input logic [31:0] addr, input int delay, input logic stall);
        int t = 0;
        repeat (delay) @(negedge clk);
        @(negedge clk);
        f_araddr  = addr;
        f_arvalid = 1'b1;
        f_rready  = !stall;
        do begin
            @(negedge clk);
            t++;
        end while (!fetch_ar_hs && t < TIMEOUT_CYCLES);
        if (!fetch_ar_hs) report_timeout("the fetch address handshake");
        f_arvalid = 1'b0;
        if (stall) begin
            t = 0;
            while (!f_rvalid && t < TIMEOUT_CYCLES) begin
                @(negedge clk);
                t++;
            end
            if (!f_rvalid) report_timeout("f_rvalid");
            // beat left waiting a few cycles
            repeat (3) @(negedge clk);
            f_rready = 1'b1;
        end
        t = 0;
        while (!fetch_r_hs && t < TIMEOUT_CYCLES) begin
            @(negedge clk);
            t++;
        end
        if (!fetch_r_hs) report_timeout("the fetch data handshake");
    endtask

    // ==============================
    // stimulus
    // ==============================

    initial begin
        logic [31:0]         a;
        logic [31:0]         fa;
        logic [1:0]          kind;
        int                  fd;
        logic                fs;
        lsu_pkg::mem_width_e w;
        rst          = 1'b1;
        raddr_change = 1'b0;
        waddr_change = 1'b0;
        raddr        = lsu_pkg::SRAM_BASE;
        waddr        = lsu_pkg::SRAM_BASE;
        wdata        = '0;
        width        = lsu_pkg::MEM_WORD;
        f_araddr     = lsu_pkg::SRAM_BASE;
        f_arvalid    = 1'b0;
        f_rready     = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (2) @(negedge clk);

        // fill the first 64 lines
        for (int i = 0; i < 128; i++) begin
            store(lsu_pkg::SRAM_BASE + 32'(i * 4), take_bits(32), lsu_pkg::MEM_WORD);
        end

        store(lsu_pkg::SRAM_BASE + 32'h40, 32'hdead_beef, lsu_pkg::MEM_WORD);
        load(lsu_pkg::SRAM_BASE + 32'h40, lsu_pkg::MEM_WORD);
        // narrow stores, neighbors seen through word loads
        store(lsu_pkg::SRAM_BASE + 32'h41, 32'h0000_00a5, lsu_pkg::MEM_BYTE);
        load(lsu_pkg::SRAM_BASE + 32'h40, lsu_pkg::MEM_WORD);
        load(lsu_pkg::SRAM_BASE + 32'h41, lsu_pkg::MEM_BYTE);
        load(lsu_pkg::SRAM_BASE + 32'h41, lsu_pkg::MEM_BYTE_U);
        store(lsu_pkg::SRAM_BASE + 32'h46, 32'h0000_8001, lsu_pkg::MEM_HALF);
        load(lsu_pkg::SRAM_BASE + 32'h44, lsu_pkg::MEM_WORD);
        load(lsu_pkg::SRAM_BASE + 32'h46, lsu_pkg::MEM_HALF);
        load(lsu_pkg::SRAM_BASE + 32'h46, lsu_pkg::MEM_HALF_U);

        // stores outside the map, then one back inside
        store(lsu_pkg::SRAM_BASE + 32'(lsu_pkg::SRAM_WORDS * 8 + 8), 32'h1234_5678,
              lsu_pkg::MEM_WORD);
        store(lsu_pkg::SRAM_BASE - 32'd4, 32'h0bad_0bad, lsu_pkg::MEM_WORD);
        store(lsu_pkg::SRAM_BASE + 32'h48, 32'h5a5a_0f0f, lsu_pkg::MEM_WORD);

        // fetch behind a pending load with a stalled ready
        fork
            load(lsu_pkg::SRAM_BASE + 32'h80, lsu_pkg::MEM_WORD);
            fetch(lsu_pkg::SRAM_BASE + 32'h40, 1, 1'b1);
        join

        for (int n = 0; n < 200; n++) begin
            kind = 2'(take_bits(2));
            if (kind == 2'd0) begin
                w = lsu_pkg::mem_width_e'(3'(take_bits(2) % 3));
                a = pick_addr(w);
                store(a, take_bits(32), w);
            end else if (kind == 2'd1) begin
                w  = lsu_pkg::mem_width_e'(3'(take_bits(3) % 5));
                a  = pick_addr(w);
                fa = pick_addr(lsu_pkg::MEM_WORD);
                fd = int'(take_bits(2));
                fs = 1'(take_bits(1));
                fork
                    load(a, w);
                    fetch(fa, fd, fs);
                join
            end else begin
                w = lsu_pkg::mem_width_e'(3'(take_bits(3) % 5));
                a = pick_addr(w);
                load(a, w);
            end
        end

        repeat (3) @(negedge clk);
        if (u_dut.u_checks.fails == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("TEST FAILED");
            $fatal(1, "assertion failures were reported");
        end
    end

endmodule

// ==== tb_mem_stage_assertions.sv ====
// bound checker for the memory stage top
// byte shadow of the SRAM contents,
// load, fetch, priority, reset and write error checks

`timescale 1ns/1ps

module tb_mem_stage_assertions (
    input logic                clk,
    input logic                rst,
    input logic [31:0]         raddr,
    input logic [31:0]         waddr,
    input logic [31:0]         wdata,
    input lsu_pkg::mem_width_e width,
    input logic [31:0]         rdata,
    input logic                rvalid,
    input logic                wready,
    input logic                error,
    input logic                d_arvalid,
    input logic [31:0]         f_araddr,
    input logic                f_arready,
    input logic [63:0]         f_rdata,
    input logic                f_rvalid,
    input logic                f_rready
);

    localparam int OFF_W = lsu_pkg::SRAM_IDX_W + 3;

    // one entry per SRAM byte, unwritten bytes stay X
    logic [7:0] shadow [lsu_pkg::SRAM_WORDS * 8];
    logic       wready_q;
    int         fails = 0;

    function automatic int access_bytes(input lsu_pkg::mem_width_e w);
        case (w)
            lsu_pkg::MEM_BYTE, lsu_pkg::MEM_BYTE_U: return 1;
            lsu_pkg::MEM_HALF, lsu_pkg::MEM_HALF_U: return 2;
            default:                                return 4;
        endcase
    endfunction

    function automatic logic [OFF_W-1:0] offset(input logic [31:0] addr);
        return OFF_W'(addr - lsu_pkg::SRAM_BASE);
    endfunction

    // every byte of the access inside the SRAM map
    function automatic logic mapped(input logic [31:0] addr, input lsu_pkg::mem_width_e w);
        logic [31:0] last;
        last = addr + 32'(access_bytes(w) - 1);
        return (addr >= lsu_pkg::SRAM_BASE)
            && (last < lsu_pkg::SRAM_BASE + 32'(lsu_pkg::SRAM_WORDS * 8));
    endfunction

    function automatic logic [31:0] expected_load(input logic [31:0] addr,
                                                  input lsu_pkg::mem_width_e w);
        logic [OFF_W-1:0] off;
        logic [7:0]       b;
        logic [15:0]      half;
        off  = offset(addr);
        b    = shadow[off];
        half = {shadow[off + OFF_W'(1)], shadow[off]};
        case (w)
            lsu_pkg::MEM_BYTE:   return {{24{b[7]}}, b};
            lsu_pkg::MEM_BYTE_U: return {24'b0, b};
            lsu_pkg::MEM_HALF:   return {{16{half[15]}}, half};
            lsu_pkg::MEM_HALF_U: return {16'b0, half};
            default:             return {shadow[off + OFF_W'(3)], shadow[off + OFF_W'(2)], half};
        endcase
    endfunction

    // whole little-endian line holding addr
    function automatic logic [63:0] expected_line(input logic [31:0] addr);
        logic [OFF_W-1:0] base;
        logic [63:0]      line;
        base = offset(addr) & ~OFF_W'(7);
        for (int i = 0; i < 8; i++) begin
            line[i*8 +: 8] = shadow[base + OFF_W'(i)];
        end
        return line;
    endfunction

    // store lands in the shadow when wready comes back
    always @(posedge clk) begin
        wready_q <= wready;
        if (!rst && wready && !wready_q && mapped(waddr, width)) begin
            for (int i = 0; i < access_bytes(width); i++) begin
                shadow[offset(waddr) + OFF_W'(i)] <= wdata[i*8 +: 8];
            end
        end
    end

    // ==============================
    // checks
    // ==============================

    a_reset_idle: assert property (@(posedge clk)
        $fell(rst) |-> rvalid && wready && !f_rvalid && !error)
        else begin
            $error("[FAIL] after reset rvalid %h wready %h f_rvalid %h error %h, expected 1 1 0 0",
                   rvalid, wready, f_rvalid, error);
            fails++;
        end

    a_load_data: assert property (@(posedge clk) disable iff (rst)
        $rose(rvalid) |-> rdata === expected_load(raddr, width))
        else begin
            $error("[FAIL] rdata got %h expected %h", rdata, expected_load(raddr, width));
            fails++;
        end

    // error follows the range of the store just finished
    a_store_error: assert property (@(posedge clk) disable iff (rst)
        $rose(wready) |-> error == !mapped(waddr, width))
        else begin
            $error("[FAIL] error got %h expected %h", error, !mapped(waddr, width));
            fails++;
        end

    // data client wins a tie for the read port
    a_data_priority: assert property (@(posedge clk) disable iff (rst)
        d_arvalid |-> !f_arready)
        else begin
            $error("[FAIL] f_arready got %h expected 0 while a load request waits", f_arready);
            fails++;
        end

    a_fetch_data: assert property (@(posedge clk) disable iff (rst)
        f_rvalid && f_rready |-> f_rdata === expected_line(f_araddr))
        else begin
            $error("[FAIL] f_rdata got %h expected %h", f_rdata, expected_line(f_araddr));
            fails++;
        end

    a_fetch_hold: assert property (@(posedge clk) disable iff (rst)
        f_rvalid && !f_rready |=> f_rvalid && $stable(f_rdata))
        else begin
            $error("fetch beat dropped or changed while f_rready was low");
            fails++;
        end

endmodule

bind mem_stage_top tb_mem_stage_assertions u_checks (.*);
